// ==== accuCpu.f ====
accuCpuPkg.sv
cpuAlu.sv
cpuDatapath.sv
cpuControl.sv
accuCpu.sv
tbClock.sv
tbMemory.sv
tbAccuCpu.sv

// ==== accuCpu.sv ====
`timescale 1ns/1ns

module accuCpu import accuCpuPkg::*; #(
    parameter int addrWidth = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [wordWidth-1:0] memRdata,
    input  logic [wordWidth-1:0] inData,
    output logic                 memWe,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWdata,
    output logic [wordWidth-1:0] outData,
    output logic                 outStrobe,
    output logic                 halted
);

    ctrlS                 ctrl;
    instrS                instr;
    logic [wordWidth-1:0] acc;
    logic [wordWidth-1:0] aluResult;

    cpuControl u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .memRdata  (memRdata),
        .ctrl      (ctrl),
        .memWe     (memWe),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    cpuDatapath #(.addrWidth(addrWidth)) u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .memRdata  (memRdata),
        .inData    (inData),
        .aluResult (aluResult),
        .instr     (instr),
        .acc       (acc),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .outData   (outData)
    );

    // Second operand comes straight off the memory bus
    cpuAlu u_alu (
        .opcode (instr.opcode),
        .a      (acc),
        .b      (memRdata),
        .result (aluResult)
    );

endmodule

// ==== accuCpuPkg.sv ====
package accuCpuPkg;

    localparam int wordWidth = 16;  // Instruction format is built on this
    localparam int progStart = 8;

    typedef enum logic [3:0] {
        opMov  = 4'b0000,
        opAdd  = 4'b0001,
        opSub  = 4'b0010,
        opMul  = 4'b0011,
        opIn   = 4'b0111,
        opOut  = 4'b1000,
        opStop = 4'b1111
    } opcodeE;

    typedef struct packed {
        logic       indirect;
        logic [2:0] addr;
    } operandS;

    typedef struct packed {
        opcodeE  opcode;  // 15:12
        operandS dst;     // 11:8
        operandS src1;    // 7:4
        operandS src2;    // 3:0
    } instrS;

    // src2 pattern of a MOV that carries an immediate word
    localparam operandS immMarker = '{indirect: 1'b1, addr: 3'd0};

    typedef enum logic [3:0] {
        stFetch0,
        stFetch1,
        stFetch2,
        stOperand,
        stIndirect,
        stExec,
        stDestIndirect,
        stWrite,
        stHalt
    } stateE;

    typedef enum logic [1:0] {marPc, marOperand, marMemData} marSelE;
    typedef enum logic [1:0] {accImm, accIn, accMem, accAlu} accSelE;
    typedef enum logic [1:0] {idxDst, idxSrc1, idxSrc2} operandIdxE;

    typedef struct packed {
        logic       incPc;
        logic       ldMar;
        marSelE     marSel;
        operandIdxE operandIdx;
        logic       ldIrHi;
        logic       ldIrLo;
        logic       ldAcc;
        accSelE     accSel;  // Also picks the MDR source
        logic       ldMdr;
        logic       ldOut;
    } ctrlS;

endpackage

// ==== cpuAlu.sv ====
`timescale 1ns/1ns

module cpuAlu import accuCpuPkg::*; (
    input  opcodeE               opcode,
    input  logic [wordWidth-1:0] a,
    input  logic [wordWidth-1:0] b,
    output logic [wordWidth-1:0] result
);

    always_comb begin
        case (opcode)
            opAdd:   result = a + b;
            opSub:   result = a - b;
            opMul:   result = a * b;  // Low half of the product
            default: result = a;
        endcase
    end

endmodule

// ==== cpuControl.sv ====
`timescale 1ns/1ns

module cpuControl import accuCpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  instrS                instr,
    input  logic [wordWidth-1:0] memRdata,
    output ctrlS                 ctrl,
    output logic                 memWe,
    output logic                 outStrobe,
    output logic                 halted
);

    stateE      state;
    stateE      stateNext;
    logic [1:0] opCnt;      // Operands already sent to the MAR
    logic [1:0] opCntNext;
    logic [1:0] opNeeded;
    operandIdxE issueIdx;
    operandS    issueOperand;
    instrS      fetched;

    function automatic logic isImmMov(instrS word);
        return (word.opcode == opMov) && (word.src2 == immMarker);
    endfunction

    assign fetched = instrS'(memRdata);

    // Source operands each opcode reads from memory
    always_comb begin
        case (instr.opcode)
            opMov:               opNeeded = isImmMov(instr) ? 2'd0 : 2'd1;
            opAdd, opSub, opMul: opNeeded = 2'd2;
            opOut:               opNeeded = 2'd1;  // dst is read, not written
            default:             opNeeded = 2'd0;
        endcase
    end

    always_comb begin
        if (instr.opcode == opOut) begin
            issueIdx = idxDst;
        end else if (opCnt == 2'd0) begin
            issueIdx = idxSrc1;
        end else begin
            issueIdx = idxSrc2;
        end
    end

    always_comb begin
        case (issueIdx)
            idxSrc1: issueOperand = instr.src1;
            idxSrc2: issueOperand = instr.src2;
            default: issueOperand = instr.dst;
        endcase
    end

    always_comb begin
        ctrl      = '0;
        stateNext = state;
        opCntNext = opCnt;

        case (state)
            stFetch0: begin
                ctrl.ldMar  = 1'b1;
                ctrl.marSel = marPc;
                ctrl.incPc  = 1'b1;
                stateNext   = stFetch1;
            end
            stFetch1: begin
                ctrl.ldIrHi = 1'b1;
                if (isImmMov(fetched)) begin
                    ctrl.ldMar  = 1'b1;  // Second word follows
                    ctrl.marSel = marPc;
                    ctrl.incPc  = 1'b1;
                    stateNext   = stFetch2;
                end else begin
                    stateNext = stOperand;
                end
            end
            stFetch2: begin
                ctrl.ldIrLo = 1'b1;
                stateNext   = stOperand;
            end
            stOperand: begin
                // First operand arrives here, src2 stays on the bus for the ALU
                if (opCnt == 2'd1) begin
                    ctrl.ldAcc  = 1'b1;
                    ctrl.accSel = accMem;
                end
                if (opCnt != opNeeded) begin
                    ctrl.ldMar      = 1'b1;
                    ctrl.marSel     = marOperand;
                    ctrl.operandIdx = issueIdx;
                    opCntNext       = opCnt + 1'b1;
                    stateNext       = issueOperand.indirect ? stIndirect : stOperand;
                end else begin
                    if (opCnt == 2'd0) begin
                        case (instr.opcode)
                            opMov: begin
                                ctrl.ldAcc  = 1'b1;
                                ctrl.accSel = accImm;
                            end
                            opIn: begin
                                ctrl.ldAcc  = 1'b1;
                                ctrl.accSel = accIn;
                            end
                            default: ;
                        endcase
                    end
                    opCntNext = '0;
                    stateNext = stExec;
                end
            end
            stIndirect: begin
                ctrl.ldMar  = 1'b1;
                ctrl.marSel = marMemData;
                stateNext   = stOperand;
            end
            stExec: begin
                case (instr.opcode)
                    opMov, opIn, opAdd, opSub, opMul: begin
                        if (instr.opcode inside {opAdd, opSub, opMul}) begin
                            ctrl.ldAcc  = 1'b1;
                            ctrl.accSel = accAlu;
                        end
                        ctrl.ldMdr      = 1'b1;
                        ctrl.ldMar      = 1'b1;
                        ctrl.marSel     = marOperand;
                        ctrl.operandIdx = idxDst;
                        stateNext = instr.dst.indirect ? stDestIndirect : stWrite;
                    end
                    opOut: begin
                        ctrl.ldOut = 1'b1;
                        stateNext  = stFetch0;
                    end
                    opStop:  stateNext = stHalt;
                    default: stateNext = stFetch0;  // Unknown opcode is a no-op
                endcase
            end
            stDestIndirect: begin
                ctrl.ldMar  = 1'b1;
                ctrl.marSel = marMemData;
                stateNext   = stWrite;
            end
            stWrite:  stateNext = stFetch0;
            stHalt:   stateNext = stHalt;  // Left only by reset
            default:  stateNext = stFetch0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stFetch0;
            opCnt     <= '0;
            outStrobe <= 1'b0;
        end else begin
            state     <= stateNext;
            opCnt     <= opCntNext;
            outStrobe <= ctrl.ldOut;
        end
    end

    assign memWe  = (state == stWrite);
    assign halted = (state == stHalt);

endmodule

// ==== cpuDatapath.sv ====
`timescale 1ns/1ns

module cpuDatapath import accuCpuPkg::*; #(
    parameter int addrWidth = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrlS                 ctrl,
    input  logic [wordWidth-1:0] memRdata,
    input  logic [wordWidth-1:0] inData,
    input  logic [wordWidth-1:0] aluResult,
    output instrS                instr,
    output logic [wordWidth-1:0] acc,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWdata,
    output logic [wordWidth-1:0] outData
);

    logic [addrWidth-1:0]   pc;
    logic [addrWidth-1:0]   mar;
    logic [addrWidth-1:0]   marNext;
    logic [addrWidth-1:0]   operandAddr;
    logic [2*wordWidth-1:0] ir;
    logic [wordWidth-1:0]   mdr;
    logic [wordWidth-1:0]   accNext;
    operandS                selOperand;

    assign instr    = instrS'(ir[2*wordWidth-1:wordWidth]);
    assign memAddr  = mar;
    assign memWdata = mdr;

    // Operand field named by the controller
    always_comb begin
        case (ctrl.operandIdx)
            idxSrc1: selOperand = instr.src1;
            idxSrc2: selOperand = instr.src2;
            default: selOperand = instr.dst;
        endcase
    end

    assign operandAddr = addrWidth'(selOperand.addr);

    always_comb begin
        case (ctrl.marSel)
            marOperand: marNext = operandAddr;
            marMemData: marNext = memRdata[addrWidth-1:0];  // Pointer word
            default:    marNext = pc;
        endcase
    end

    always_comb begin
        case (ctrl.accSel)
            accImm:  accNext = ir[wordWidth-1:0];
            accIn:   accNext = inData;
            accMem:  accNext = memRdata;
            default: accNext = aluResult;
        endcase
    end

    // MAR starts at the program so the first fetch address is out at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= addrWidth'(progStart);
            mar     <= addrWidth'(progStart);
            outData <= '0;
        end else begin
            if (ctrl.incPc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.ldMar) begin
                mar <= marNext;
            end
            if (ctrl.ldOut) begin
                outData <= acc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldIrHi) begin
            ir[2*wordWidth-1:wordWidth] <= memRdata;
        end
        if (ctrl.ldIrLo) begin
            ir[wordWidth-1:0] <= memRdata;  // Immediate word
        end
        if (ctrl.ldAcc) begin
            acc <= accNext;
        end
        if (ctrl.ldMdr) begin
            mdr <= (ctrl.accSel == accAlu) ? aluResult : acc;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run; exit status is nonzero on failure
verilator --binary --timing --top-module tbAccuCpu -f accuCpu.f -o simAccuCpu \
    && ./obj_dir/simAccuCpu \
    || exit 1

// ==== tbAccuCpu.sv ====
`timescale 1ns/1ns

module tbAccuCpu import accuCpuPkg::*; ;

    typedef struct packed {
        opcodeE      op;
        logic        imm;
        logic        dstInd;
        logic        s1Ind;
        logic        s2Ind;
        logic        illegal;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] inVal;
        logic [15:0] expected;
    } caseS;

    logic        clk;
    logic        rst_n;
    logic [15:0] memRdata;
    logic [15:0] inData;
    logic        memWe;
    logic [5:0]  memAddr;
    logic [15:0] memWdata;
    logic [15:0] outData;
    logic        outStrobe;
    logic        halted;
    integer      seed;
    caseS        cases [$];

    tbClock u_clk (.clk(clk), .rst_n(rst_n));

    tbMemory u_mem (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    accuCpu u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .memRdata  (memRdata),
        .inData    (inData),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .outData   (outData),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    // Instruction rules, modulo 2^16
    function automatic logic [15:0] expectedResult(opcodeE op, logic [15:0] a,
                                                   logic [15:0] b, logic [15:0] inVal);
        logic [31:0] prod;
        prod = 32'(a) * 32'(b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opMul:   return prod[15:0];
            opIn:    return inVal;
            default: return a;  // MOV, immediate kept in a
        endcase
    endfunction

    function automatic logic [15:0] randomWord();
        return 16'($random(seed));
    endfunction

    function automatic caseS makeCase(opcodeE op, logic imm, logic dstInd, logic s1Ind,
                                      logic s2Ind, logic illegal, logic [15:0] a,
                                      logic [15:0] b, logic [15:0] inVal);
        caseS c;
        c = '{op, imm, dstInd, s1Ind, s2Ind, illegal, a, b, inVal, 16'h0};
        c.expected = expectedResult(op, a, b, inVal);
        return c;
    endfunction

    task automatic checkWord(string what, logic [15:0] got, logic [15:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "wrong value");
        end
    endtask

    task automatic loadProgram(caseS c);
        logic [3:0] dstF;
        logic [3:0] s1F;
        logic [3:0] s2F;
        int         pc;
        dstF = c.dstInd ? 4'hF : 4'h3;
        s1F  = c.s1Ind ? 4'hD : 4'h1;
        s2F  = c.imm ? 4'h8 : (c.s2Ind ? 4'hE : 4'h2);
        pc   = 8;
        u_mem.fillPattern();
        u_mem.writeWord(1, c.a);
        u_mem.writeWord(2, c.b);
        u_mem.writeWord(40, c.a);
        u_mem.writeWord(41, c.b);
        u_mem.writeWord(5, 16'd40);  // Pointers
        u_mem.writeWord(6, 16'd41);
        u_mem.writeWord(7, 16'd42);
        u_mem.writeWord(pc++, {c.op, dstF, s1F, s2F});
        if (c.imm) begin
            u_mem.writeWord(pc++, c.a);
        end
        u_mem.writeWord(pc++, {opOut, dstF, 8'h00});
        if (c.illegal) begin
            u_mem.writeWord(pc++, 16'h4123);
        end
        u_mem.writeWord(pc, {opStop, 12'h000});
    endtask

    task automatic runCase(caseS c);
        int cycles;
        int strobes;
        int writes;
        cycles  = 0;
        strobes = 0;
        writes  = 0;
        u_clk.assertReset();
        loadProgram(c);
        @(negedge clk);
        checkWord("memWe in reset", 16'(memWe), 16'h0);
        checkWord("outStrobe in reset", 16'(outStrobe), 16'h0);
        checkWord("halted in reset", 16'(halted), 16'h0);
        checkWord("outData in reset", outData, 16'h0);
        checkWord("first memAddr", 16'(memAddr), 16'd8);
        u_clk.releaseReset();
        inData = c.inVal;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            strobes += int'(outStrobe);
            writes  += int'(memWe);
            if (memWe) begin
                checkWord("memWdata", memWdata, c.expected);
            end
            if (cycles > 200) begin
                $display("Timeout: the CPU never halted within 200 cycles");
                $display("** FAIL **");
                $fatal(1, "timeout");
            end
        end
        checkWord("mem[dst]", u_mem.readWord(c.dstInd ? 42 : 3), c.expected);
        checkWord("outData", outData, c.expected);
        checkWord("outStrobe pulses", 16'(strobes), 16'd1);
        checkWord("memWe pulses", 16'(writes), 16'd1);
        for (int i = 5; i < 8; i++) begin
            checkWord("pointer word", u_mem.readWord(i), 16'(35 + i));
        end
        // Illegal word 4123 names address 1 as its dst
        checkWord("illegal dst word", u_mem.readWord(1), c.a);
        repeat (20) begin
            @(negedge clk);
            checkWord("memWe after stop", 16'(memWe), 16'h0);
            checkWord("outStrobe after stop", 16'(outStrobe), 16'h0);
            checkWord("halted after stop", 16'(halted), 16'h1);
        end
    endtask

    initial begin
        seed   = 75220;
        inData = 16'h0;
        // op, imm, dstInd, s1Ind, s2Ind, illegal, a, b, inData
        cases.push_back(makeCase(opMov, 1, 0, 0, 0, 0, 16'h1234, 16'h0, 16'h0));
        cases.push_back(makeCase(opMov, 0, 0, 0, 0, 0, randomWord(), 16'h0, 16'h0));
        cases.push_back(makeCase(opAdd, 0, 0, 0, 0, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opAdd, 0, 0, 0, 0, 0, 16'hFFFF, 16'h0001, 16'h0));
        cases.push_back(makeCase(opSub, 0, 0, 0, 0, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opSub, 0, 0, 0, 0, 0, 16'h0000, 16'h0001, 16'h0));
        cases.push_back(makeCase(opMul, 0, 0, 0, 0, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opMul, 0, 0, 0, 0, 0, 16'hFFFF, 16'hFFFF, 16'h0));
        cases.push_back(makeCase(opAdd, 0, 1, 1, 1, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opMul, 0, 0, 1, 0, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opSub, 0, 1, 0, 1, 0, randomWord(), randomWord(), 16'h0));
        cases.push_back(makeCase(opMov, 0, 1, 1, 0, 0, randomWord(), 16'h0, 16'h0));
        cases.push_back(makeCase(opIn, 0, 0, 0, 0, 0, 16'h0, 16'h0, 16'hBEEF));
        cases.push_back(makeCase(opIn, 0, 1, 0, 0, 1, 16'h0, 16'h0, randomWord()));
        cases.push_back(makeCase(opMov, 1, 1, 0, 0, 1, 16'h8001, 16'h0, 16'h0));
        #1;  // First reset edge after time zero
        foreach (cases[i]) begin
            runCase(cases[i]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b1;  // Pulled low by the testbench after time zero
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic assertReset();
        rst_n = 1'b0;
    endtask

    // Released 1 ns after a rising edge
    task automatic releaseReset();
        repeat (resetCycles) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

endmodule

// ==== tbMemory.sv ====
`timescale 1ns/1ns

module tbMemory (
    input  logic        clk,
    input  logic        we,
    input  logic [5:0]  addr,
    input  logic [15:0] wdata,
    output logic [15:0] rdata
);

    logic [15:0] mem [64];

    assign rdata = mem[addr];  // Asynchronous read

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    task automatic writeWord(input int a, input logic [15:0] d);
        mem[a] = d;
    endtask

    function automatic logic [15:0] readWord(input int a);
        return mem[a];
    endfunction

    // Every word carries its own address
    task automatic fillPattern();
        for (int i = 0; i < 64; i++) begin
            mem[i] = 16'hC000 | 16'(i);
        end
    endtask

endmodule
